//--- Makefile
# Verilator build and run for the multiply unit testbench.

VERILATOR ?= verilator
TOP       ?= mult_unit_tb
FILE_LIST ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?=

SOURCES := $(shell grep -v '^+' $(FILE_LIST))
BINARY  := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(BINARY)

$(BINARY): $(SOURCES) $(FILE_LIST)
	$(VERILATOR) --binary --timing --top-module $(TOP) -Mdir $(BUILD_DIR) \
		-f $(FILE_LIST) $(VFLAGS)

run: $(BINARY)
	./$(BINARY) | tee $(LOG)
	@if grep -q '\*\*\* TEST FAILED \*\*\*' $(LOG); then \
		echo "Simulation reported failure"; exit 1; \
	fi
	@if ! grep -q '\*\*\* TEST PASSED \*\*\*' $(LOG); then \
		echo "Simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- bench/mult_unit_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit_tb import mult_unit_pkg::*; ();

	localparam int XLEN = 32;
	localparam int NUM_STAGE = 4;
	localparam int PR_WIDTH = 6;
	localparam int ROB_WIDTH = 5;
	localparam int TOTAL_ISSUES = 16 + 200 + 200 + 2 * NUM_STAGE + 300;
	localparam int TIMEOUT_CYCLES = TOTAL_ISSUES * (NUM_STAGE + 4) + 200;
	localparam int HELD_WIDTH = XLEN + PR_WIDTH + ROB_WIDTH + 2;

	typedef struct packed {
		logic [XLEN-1:0]      value;
		logic [PR_WIDTH-1:0]  dest_pr;
		logic [ROB_WIDTH-1:0] rob_entry;
		logic                 halt;
		logic [31:0]          cycle;
	} expect_t;

	logic                 clock;
	logic                 reset;
	logic                 issue_valid;
	mult_op_t             issue_op;
	logic [XLEN-1:0]      rs1_value;
	logic [XLEN-1:0]      rs2_value;
	logic [PR_WIDTH-1:0]  issue_dest_pr;
	logic [ROB_WIDTH-1:0] issue_rob_entry;
	logic                 issue_halt;
	logic                 complete_stall;
	logic                 fu_ready;
	logic                 complete_valid;
	logic [XLEN-1:0]      complete_value;
	logic [PR_WIDTH-1:0]  complete_dest_pr;
	logic [ROB_WIDTH-1:0] complete_rob_entry;
	logic                 complete_halt;

	expect_t               expected_q[$];
	logic [31:0]           rand_state = 32'h173a_c59c;
	logic [HELD_WIDTH-1:0] held;
	logic                  hold_valid = 1'b0;
	logic                  accepted = 1'b0;
	logic                  ready_seen = 1'b0;
	logic                  check_latency = 1'b0;
	logic                  check_ready = 1'b0;
	string                 test_name = "reset";
	int                    cycle_index = 0;
	int                    error_count = 0;
	int                    tests_passed = 0;
	int                    tests_failed = 0;

	mult_unit_top #(
		.XLEN      (XLEN),
		.NUM_STAGE (NUM_STAGE),
		.PR_WIDTH  (PR_WIDTH),
		.ROB_WIDTH (ROB_WIDTH)
	) dut (.*);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	// Bounds the whole run by the number of clock cycles.
	initial begin
		int cycles;
		cycles = 0;
		while (cycles < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycles++;
		end
		$display("Timeout in %s after %0d cycles", test_name, cycles);
		$display("*** TEST FAILED ***");
		$finish;
	end

	// ========================================================================
	// Random numbers and the reference model.
	// ========================================================================

	function automatic logic [31:0] next_rand();
		rand_state = rand_state * 32'd1664525 + 32'd1013904223;
		return rand_state;
	endfunction

	function automatic logic chance(input int percent);
		logic [31:0] r;
		r = next_rand();
		return ((r >> 8) % 100) < percent;
	endfunction

	// Full 64-bit product of the extended operands, then the half the operation asks for.
	function automatic logic [XLEN-1:0] model_result(input mult_op_t op,
			input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [2*XLEN-1:0] wide_a;
		logic [2*XLEN-1:0] wide_b;
		logic [2*XLEN-1:0] product;
		logic              a_signed;
		logic              b_signed;
		a_signed = (op != MULHU);
		b_signed = (op == MUL) || (op == MULH);
		wide_a = {{XLEN{a_signed & a[XLEN-1]}}, a};
		wide_b = {{XLEN{b_signed & b[XLEN-1]}}, b};
		product = wide_a * wide_b;
		return (op == MUL) ? product[XLEN-1:0] : product[2*XLEN-1:XLEN];
	endfunction

	task automatic mismatch(input string field, input logic [63:0] expected,
			input logic [63:0] actual);
		error_count++;
		$display("Mismatch in %s: %s expected %0h, actual %0h", test_name, field, expected, actual);
	endtask

	task automatic check_completion(input expect_t e);
		if (complete_value !== e.value) mismatch("value", 64'(e.value), 64'(complete_value));
		if (complete_dest_pr !== e.dest_pr) begin
			mismatch("dest_pr", 64'(e.dest_pr), 64'(complete_dest_pr));
		end
		if (complete_rob_entry !== e.rob_entry) begin
			mismatch("rob_entry", 64'(e.rob_entry), 64'(complete_rob_entry));
		end
		if (complete_halt !== e.halt) mismatch("halt", 64'(e.halt), 64'(complete_halt));
		if (check_latency && (cycle_index - int'(e.cycle) != NUM_STAGE)) begin
			mismatch("latency", 64'(NUM_STAGE), 64'(cycle_index - int'(e.cycle)));
		end
	endtask

	// ========================================================================
	// One clock cycle. Outputs are sampled at the falling edge, where they are settled.
	// ========================================================================

	task automatic step();
		expect_t e;
		@(negedge clock);
		if (hold_valid && (held !== {complete_valid, complete_value, complete_dest_pr,
				complete_rob_entry, complete_halt})) begin
			mismatch("held completion", 64'(held), 64'({complete_valid, complete_value,
				complete_dest_pr, complete_rob_entry, complete_halt}));
		end
		if (complete_valid && !complete_stall) begin // Taken on the coming edge.
			if (expected_q.size() == 0) begin
				error_count++;
				$display("Error in %s: a completion arrived with nothing outstanding", test_name);
			end else begin
				e = expected_q.pop_front();
				check_completion(e);
			end
		end
		accepted = issue_valid && fu_ready;
		ready_seen = fu_ready;
		if (accepted) begin
			e.value = model_result(issue_op, rs1_value, rs2_value);
			e.dest_pr = issue_dest_pr;
			e.rob_entry = issue_rob_entry;
			e.halt = issue_halt;
			e.cycle = 32'(cycle_index);
			expected_q.push_back(e);
		end
		if (check_ready && !fu_ready) begin
			error_count++;
			$display("Error in %s: fu_ready dropped with no stall", test_name);
		end
		hold_valid = complete_valid && complete_stall;
		held = {complete_valid, complete_value, complete_dest_pr, complete_rob_entry, complete_halt};
		cycle_index++;
		@(posedge clock);
		#1;
	endtask

	task automatic present(input mult_op_t op, input logic [XLEN-1:0] a, input logic [XLEN-1:0] b);
		logic [31:0] r;
		r = next_rand();
		issue_valid = 1'b1;
		issue_op = op;
		rs1_value = a;
		rs2_value = b;
		issue_dest_pr = r[PR_WIDTH-1:0];
		issue_rob_entry = r[PR_WIDTH+ROB_WIDTH-1:PR_WIDTH];
		issue_halt = (r[15:12] == 4'd0);
	endtask

	task automatic present_random(input int slot, input logic rotate);
		mult_op_t op;
		op = rotate ? mult_op_t'(slot[1:0]) : mult_op_t'(next_rand() >> 30);
		present(op, next_rand(), next_rand());
	endtask

	task automatic drain();
		int n;
		n = 0;
		issue_valid = 1'b0;
		complete_stall = 1'b0;
		while (expected_q.size() > 0 && n < NUM_STAGE + 4) begin
			step();
			n++;
		end
		if (expected_q.size() != 0) begin
			error_count++;
			$display("Error in %s: %0d results never came out", test_name, expected_q.size());
			expected_q.delete();
		end
	endtask

	task automatic finish_test(input int errors_before);
		if (error_count == errors_before) begin
			tests_passed++;
			$display("Test %s: passed", test_name);
		end else begin
			tests_failed++;
			$display("Test %s: failed with %0d errors", test_name, error_count - errors_before);
		end
	endtask

	task automatic run_random(input int count, input int issue_pct, input int stall_pct,
			input logic rotate);
		int issued;
		logic pending;
		issued = 0;
		pending = 1'b0;
		while (issued < count) begin
			if (!pending && chance(issue_pct)) begin
				present_random(issued, rotate);
				pending = 1'b1;
			end
			complete_stall = chance(stall_pct);
			step();
			if (accepted) begin
				issued++;
				pending = 1'b0;
				issue_valid = 1'b0;
			end
		end
		drain();
	endtask

	// ========================================================================
	// Test sequence.
	// ========================================================================

	initial begin
		logic [XLEN-1:0] corner [4];
		int errors_before;
		int accepts;
		corner = '{32'h0000_0000, 32'hffff_ffff, 32'h8000_0000, 32'h7fff_ffff};
		reset = 1'b1;
		issue_valid = 1'b0;
		issue_op = MUL;
		rs1_value = '0;
		rs2_value = '0;
		issue_dest_pr = '0;
		issue_rob_entry = '0;
		issue_halt = 1'b0;
		complete_stall = 1'b0;
		repeat (8) @(posedge clock);
		#1;
		reset = 1'b0;

		test_name = "reset_state";
		errors_before = error_count;
		step();
		if (complete_valid !== 1'b0) mismatch("complete_valid", 64'd0, 64'(complete_valid));
		if (ready_seen !== 1'b1) mismatch("fu_ready", 64'd1, 64'(ready_seen));
		finish_test(errors_before);

		test_name = "single_latency";
		errors_before = error_count;
		check_latency = 1'b1;
		for (int o = 0; o < 4; o++) begin
			for (int k = 0; k < 4; k++) begin
				present(mult_op_t'(o[1:0]), corner[k], corner[(k + o) % 4]);
				step();
				issue_valid = 1'b0;
				drain();
				step(); // A gap keeps each operation on its own.
			end
		end
		check_latency = 1'b0;
		finish_test(errors_before);

		test_name = "back_to_back";
		errors_before = error_count;
		check_ready = 1'b1;
		run_random(200, 100, 0, 1'b0);
		check_ready = 1'b0;
		finish_test(errors_before);

		test_name = "stall_hold";
		errors_before = error_count;
		run_random(200, 70, 40, 1'b0);
		finish_test(errors_before);

		test_name = "backpressure_fill";
		errors_before = error_count;
		accepts = 0;
		complete_stall = 1'b1;
		present_random(0, 1'b0);
		for (int c = 0; c < 3 * NUM_STAGE; c++) begin
			step();
			if (accepted) begin
				accepts++;
				present_random(0, 1'b0); // The issuer keeps presenting while refused.
			end
		end
		if (accepts != NUM_STAGE) mismatch("accepts before full", 64'(NUM_STAGE), 64'(accepts));
		if (ready_seen !== 1'b0) mismatch("fu_ready when full", 64'd0, 64'(ready_seen));
		complete_stall = 1'b0;
		while (accepts < 2 * NUM_STAGE) begin
			step();
			if (accepted) begin
				accepts++;
				present_random(0, 1'b0);
			end
		end
		drain();
		finish_test(errors_before);

		test_name = "op_sweep";
		errors_before = error_count;
		run_random(300, 70, 25, 1'b1);
		finish_test(errors_before);

		$display("Tests passed: %0d, failed: %0d, errors: %0d", tests_passed, tests_failed,
			error_count);
		if (tests_failed == 0 && error_count == 0) begin
			$display("*** TEST PASSED ***");
		end else begin
			$display("*** TEST FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

//--- files.f
source/mult_unit_pkg.sv
source/stage_bus_if.sv
source/operand_prep.sv
source/mult_stage.sv
source/mult_pipeline.sv
source/mult_control.sv
source/result_select.sv
source/mult_unit_top.sv
bench/mult_unit_tb.sv

//--- source/mult_control.sv
`timescale 1ns/1ps
`default_nettype none

module mult_control #(
	parameter int NUM_STAGE = 4
) (
	input  logic [NUM_STAGE-1:0]  stage_valid,
	input  logic                  complete_stall,
	input  logic                  issue_valid,
	output logic [NUM_STAGE-1:0]  stage_enable,
	output logic                  accept,
	output logic                  fu_ready
);

	// ========================================================================
	// Enable chain, worked out backward from writeback.
	// ========================================================================

	// A stage may load when it is empty or when its contents move on this cycle.
	// So an empty stage behind a stalled one still takes work, and bubbles collapse.
	always_comb begin
		stage_enable[NUM_STAGE-1] = ~stage_valid[NUM_STAGE-1] | ~complete_stall;
		for (int i = NUM_STAGE - 2; i >= 0; i--) begin
			stage_enable[i] = ~stage_valid[i] | stage_enable[i+1];
		end
	end

	assign fu_ready = stage_enable[0];
	assign accept   = issue_valid & stage_enable[0]; // Issue only lands when stage 0 loads.

endmodule

`default_nettype wire

//--- source/mult_pipeline.sv
`timescale 1ns/1ps
`default_nettype none

module mult_pipeline #(
	parameter int XLEN = 32,
	parameter int NUM_STAGE = 4,
	parameter int TAG_WIDTH = 16
) (
	input  logic                  clock,
	input  logic                  reset,
	input  logic [NUM_STAGE-1:0]  stage_enable,
	stage_bus_if.sink             head,
	stage_bus_if.source           tail,
	output logic [NUM_STAGE-1:0]  stage_valid
);

	// Link i feeds stage i; link NUM_STAGE holds the last stage's output.
	stage_bus_if #(.XLEN(XLEN), .TAG_WIDTH(TAG_WIDTH)) link [NUM_STAGE:0] ();

	assign link[0].valid   = head.valid;
	assign link[0].mcand   = head.mcand;
	assign link[0].mplier  = head.mplier;
	assign link[0].product = head.product;
	assign link[0].tag     = head.tag;

	// ========================================================================
	// Stage chain.
	// ========================================================================

	for (genvar i = 0; i < NUM_STAGE; i++) begin : g_stage
		mult_stage #(
			.XLEN      (XLEN),
			.NUM_STAGE (NUM_STAGE)
		) stage (
			.clock  (clock),
			.reset  (reset),
			.enable (stage_enable[i]),
			.in     (link[i].sink),
			.out    (link[i+1].source)
		);

		assign stage_valid[i] = link[i+1].valid; // Occupancy seen by the control block.
	end

	assign tail.valid   = link[NUM_STAGE].valid;
	assign tail.mcand   = link[NUM_STAGE].mcand;
	assign tail.mplier  = link[NUM_STAGE].mplier;
	assign tail.product = link[NUM_STAGE].product;
	assign tail.tag     = link[NUM_STAGE].tag;

endmodule

`default_nettype wire

//--- source/mult_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mult_stage #(
	parameter int XLEN = 32,
	parameter int NUM_STAGE = 4
) (
	input  logic         clock,
	input  logic         reset,
	input  logic         enable,
	stage_bus_if.sink    in,
	stage_bus_if.source  out
);

	// Multiplier bits consumed by each stage.
	localparam int NUM_BITS = (2 * XLEN) / NUM_STAGE;

	logic [2*XLEN-1:0] mplier_slice;
	logic [2*XLEN-1:0] next_partial;
	logic [2*XLEN-1:0] product_reg;
	logic [2*XLEN-1:0] partial_reg;

	assign mplier_slice = {{(2*XLEN-NUM_BITS){1'b0}}, in.mplier[NUM_BITS-1:0]};
	assign next_partial = mplier_slice * in.mcand;

	// ========================================================================
	// Stage registers. A disabled stage holds everything it has.
	// ========================================================================

	always_ff @(posedge clock) begin
		if (enable) begin
			product_reg <= in.product;
			partial_reg <= next_partial;
			out.mplier  <= in.mplier >> NUM_BITS;
			out.mcand   <= in.mcand << NUM_BITS;
			out.tag     <= in.tag;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			out.valid <= 1'b0;
		end else if (enable) begin
			out.valid <= in.valid;
		end
	end

	// The add sits after the register, so it overlaps with the next stage's multiply.
	assign out.product = product_reg + partial_reg;

endmodule

`default_nettype wire

//--- source/mult_unit_pkg.sv
`default_nettype none

package mult_unit_pkg;

	// ========================================================================
	// Multiply operation codes, as decoded from funct3 of the M extension.
	// ========================================================================

	typedef enum logic [1:0] {
		MUL    = 2'b00,
		MULH   = 2'b01,
		MULHSU = 2'b10,
		MULHU  = 2'b11
	} mult_op_t;

	// ========================================================================
	// Operand and result helpers.
	// ========================================================================

	// Bit 0 says rs1 (the multiplicand) is signed, bit 1 says rs2 (the multiplier) is signed.
	// The low half of the product does not depend on signedness, so MUL simply follows MULH.
	function automatic logic [1:0] op_signs(input mult_op_t op);
		logic [1:0] signs;
		case (op)
			MUL, MULH: signs = 2'b11;
			MULHSU:    signs = 2'b01; // Only rs1 is signed.
			default:   signs = 2'b00;
		endcase
		return signs;
	endfunction

	// Every operation but MUL returns the upper XLEN bits.
	function automatic logic op_high_half(input mult_op_t op);
		logic high;
		high = (op != MUL);
		return high;
	endfunction

endpackage

`default_nettype wire

//--- source/mult_unit_top.sv
`timescale 1ns/1ps
`default_nettype none

module mult_unit_top import mult_unit_pkg::*; #(
	parameter int XLEN = 32,
	parameter int NUM_STAGE = 4,
	parameter int PR_WIDTH = 6,
	parameter int ROB_WIDTH = 5
) (
	input  logic                   clock,
	input  logic                   reset,
	input  logic                   issue_valid,
	input  mult_op_t               issue_op,
	input  logic [XLEN-1:0]        rs1_value,
	input  logic [XLEN-1:0]        rs2_value,
	input  logic [PR_WIDTH-1:0]    issue_dest_pr,
	input  logic [ROB_WIDTH-1:0]   issue_rob_entry,
	input  logic                   issue_halt,
	input  logic                   complete_stall,
	output logic                   fu_ready,
	output logic                   complete_valid,
	output logic [XLEN-1:0]        complete_value,
	output logic [PR_WIDTH-1:0]    complete_dest_pr,
	output logic [ROB_WIDTH-1:0]   complete_rob_entry,
	output logic                   complete_halt
);

	// Destination register, ROB entry, halt bit and the two operation bits.
	localparam int TAG_WIDTH = PR_WIDTH + ROB_WIDTH + 3;

	logic                  accept;
	logic [NUM_STAGE-1:0]  stage_valid;
	logic [NUM_STAGE-1:0]  stage_enable;

	stage_bus_if #(.XLEN(XLEN), .TAG_WIDTH(TAG_WIDTH)) head ();
	stage_bus_if #(.XLEN(XLEN), .TAG_WIDTH(TAG_WIDTH)) tail ();

	operand_prep #(.XLEN(XLEN), .PR_WIDTH(PR_WIDTH), .ROB_WIDTH(ROB_WIDTH)) prep (
		.op        (issue_op),
		.rs1_value (rs1_value),
		.rs2_value (rs2_value),
		.dest_pr   (issue_dest_pr),
		.rob_entry (issue_rob_entry),
		.halt      (issue_halt),
		.accept    (accept),
		.out       (head.source)
	);

	mult_pipeline #(.XLEN(XLEN), .NUM_STAGE(NUM_STAGE), .TAG_WIDTH(TAG_WIDTH)) pipeline (
		.clock        (clock),
		.reset        (reset),
		.stage_enable (stage_enable),
		.head         (head.sink),
		.tail         (tail.source),
		.stage_valid  (stage_valid)
	);

	mult_control #(.NUM_STAGE(NUM_STAGE)) control (
		.stage_valid    (stage_valid),
		.complete_stall (complete_stall),
		.issue_valid    (issue_valid),
		.stage_enable   (stage_enable),
		.accept         (accept),
		.fu_ready       (fu_ready)
	);

	result_select #(.XLEN(XLEN), .PR_WIDTH(PR_WIDTH), .ROB_WIDTH(ROB_WIDTH)) select (
		.in                 (tail.sink),
		.complete_valid     (complete_valid),
		.complete_value     (complete_value),
		.complete_dest_pr   (complete_dest_pr),
		.complete_rob_entry (complete_rob_entry),
		.complete_halt      (complete_halt)
	);

endmodule

`default_nettype wire

//--- source/operand_prep.sv
`timescale 1ns/1ps
`default_nettype none

module operand_prep import mult_unit_pkg::*; #(
	parameter int XLEN = 32,
	parameter int PR_WIDTH = 6,
	parameter int ROB_WIDTH = 5
) (
	input  mult_op_t               op,
	input  logic [XLEN-1:0]        rs1_value,
	input  logic [XLEN-1:0]        rs2_value,
	input  logic [PR_WIDTH-1:0]    dest_pr,
	input  logic [ROB_WIDTH-1:0]   rob_entry,
	input  logic                   halt,
	input  logic                   accept,
	stage_bus_if.source            out
);

	logic [1:0] signs;
	logic       rs1_fill;
	logic       rs2_fill;

	assign signs = op_signs(op);

	// Upper half is filled with the sign bit only for a signed operand.
	assign rs1_fill = signs[0] & rs1_value[XLEN-1];
	assign rs2_fill = signs[1] & rs2_value[XLEN-1];

	assign out.mcand   = {{XLEN{rs1_fill}}, rs1_value};
	assign out.mplier  = {{XLEN{rs2_fill}}, rs2_value};
	assign out.product = '0; // The running sum starts empty.
	assign out.valid   = accept;

	// Tag layout, high to low: operation, halt, ROB entry, destination register.
	assign out.tag = {op, halt, rob_entry, dest_pr};

endmodule

`default_nettype wire

//--- source/result_select.sv
`timescale 1ns/1ps
`default_nettype none

module result_select import mult_unit_pkg::*; #(
	parameter int XLEN = 32,
	parameter int PR_WIDTH = 6,
	parameter int ROB_WIDTH = 5
) (
	stage_bus_if.sink              in,
	output logic                   complete_valid,
	output logic [XLEN-1:0]        complete_value,
	output logic [PR_WIDTH-1:0]    complete_dest_pr,
	output logic [ROB_WIDTH-1:0]   complete_rob_entry,
	output logic                   complete_halt
);

	localparam int HALT_BIT = PR_WIDTH + ROB_WIDTH;
	localparam int OP_LSB   = HALT_BIT + 1;

	mult_op_t op;

	// Same layout as packed by operand_prep.
	assign op                 = mult_op_t'(in.tag[OP_LSB+1:OP_LSB]);
	assign complete_halt      = in.tag[HALT_BIT];
	assign complete_rob_entry = in.tag[HALT_BIT-1:PR_WIDTH];
	assign complete_dest_pr   = in.tag[PR_WIDTH-1:0];

	assign complete_value = op_high_half(op) ? in.product[2*XLEN-1:XLEN] : in.product[XLEN-1:0];
	assign complete_valid = in.valid;

endmodule

`default_nettype wire

//--- source/stage_bus_if.sv
`timescale 1ns/1ps
`default_nettype none

// One hop of the multiply pipeline, from a stage to the next one.
interface stage_bus_if #(
	parameter int XLEN = 32,
	parameter int TAG_WIDTH = 16
);

	logic                   valid;
	logic [2*XLEN-1:0]      mcand;
	logic [2*XLEN-1:0]      mplier;
	logic [2*XLEN-1:0]      product;
	logic [TAG_WIDTH-1:0]   tag;

	modport source (
		output valid, mcand, mplier, product, tag
	);

	modport sink (
		input valid, mcand, mplier, product, tag
	);

endinterface

`default_nettype wire
